// ==== Makefile ====
# Verilator build and run for the vector decode pipeline

VERILATOR ?= verilator
TOP       ?= vdec_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator, run it, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

// ==== files.f ====
+incdir+verilog
+incdir+tb
verilog/vinstr_pkg.sv
verilog/vctrl_pkg.sv
verilog/vdec_credit.sv
verilog/vop_decoder.sv
verilog/vctrl_gen.sv
verilog/vdec_top.sv
tb/vdec_tb.sv

// ==== tb/vdec_model.svh ====
// vector decode reference model
// expected control bundle per instruction, directed encoder and
// random instruction generator for the decode testbench

`ifndef VDEC_MODEL_SVH
`define VDEC_MODEL_SVH

// allowed funct3 set as {vi, vx, vv} plus the controls of a legal op
typedef struct packed {
  logic [2:0] allowed;
  aluop_t     alu;
  comp_t      cmp;
  minmax_t    mm;
  logic       sgn;
} op_rule_s;

// supported funct6 codes with entry 0 in the low bits
localparam logic [6*21-1:0] KEPT_FUNCT6 = {
  6'b101001, 6'b101000, 6'b100101, 6'b011111, 6'b011110, 6'b011101, 6'b011100,
  6'b011011, 6'b011010, 6'b011001, 6'b011000, 6'b001011, 6'b001010, 6'b001001,
  6'b000111, 6'b000110, 6'b000101, 6'b000100, 6'b000011, 6'b000010, 6'b000000
};

function automatic op_rule_s op_rule(input logic [5:0] f6);
  case (f6)
    6'b000000: return '{3'b111, ADD, VSEQ, MIN, 1'b1};
    6'b000010: return '{3'b011, SUB, VSEQ, MIN, 1'b1};
    6'b000011: return '{3'b110, SUB, VSEQ, MIN, 1'b1};
    6'b000100: return '{3'b011, MM, VSEQ, MINU, 1'b0};
    6'b000101: return '{3'b011, MM, VSEQ, MIN, 1'b1};
    6'b000110: return '{3'b011, MM, VSEQ, MAXU, 1'b0};
    6'b000111: return '{3'b011, MM, VSEQ, MAX, 1'b1};
    6'b001001: return '{3'b111, AND, VSEQ, MIN, 1'b0};
    6'b001010: return '{3'b111, OR, VSEQ, MIN, 1'b0};
    6'b001011: return '{3'b111, XOR, VSEQ, MIN, 1'b0};
    6'b011000: return '{3'b111, COMP, VSEQ, MIN, 1'b1};
    6'b011001: return '{3'b111, COMP, VSNE, MIN, 1'b1};
    6'b011010: return '{3'b011, COMP, VSLTU, MIN, 1'b0};
    6'b011011: return '{3'b011, COMP, VSLT, MIN, 1'b1};
    6'b011100: return '{3'b111, COMP, VSLEU, MIN, 1'b0};
    6'b011101: return '{3'b111, COMP, VSLE, MIN, 1'b1};
    6'b011110: return '{3'b110, COMP, VSGTU, MIN, 1'b0};
    6'b011111: return '{3'b110, COMP, VSGT, MIN, 1'b1};
    6'b100101: return '{3'b111, SLL, VSEQ, MIN, 1'b0};
    6'b101000: return '{3'b111, SRL, VSEQ, MIN, 1'b0};
    6'b101001: return '{3'b111, SRA, VSEQ, MIN, 1'b0};
    default:   return '{3'b000, ADD, VSEQ, MIN, 1'b0};
  endcase
endfunction

function automatic vctrl_s expected_ctrl(input instr_t w);
  vctrl_s     e;
  op_rule_s   rule;
  logic       is_vec;
  logic [2:0] f3;
  logic       legal_op;
  logic       shift;
  is_vec = (w[6:0] == 7'b1010111);
  f3     = w[14:12];
  rule   = op_rule(w[31:26]);
  legal_op = is_vec && (((f3 == 3'b000) && rule.allowed[0]) ||
                        ((f3 == 3'b100) && rule.allowed[1]) ||
                        ((f3 == 3'b011) && rule.allowed[2]));
  // anything not a legal op falls back to the neutral controls
  if (!legal_op) begin
    rule = '{3'b000, ADD, VSEQ, MIN, 1'b0};
  end
  e = '0;
  if (is_vec && (f3 == 3'b111)) begin
    if (!w[31]) begin
      e.cfgsel = VSETVLI;
    end else if (w[30]) begin
      e.cfgsel = VSETIVLI;
    end else begin
      e.cfgsel = VSETVL;
    end
  end
  e.illegal   = !legal_op && (e.cfgsel == NOT_CFG);
  e.aluop     = rule.alu;
  e.comp      = rule.cmp;
  e.minmax    = rule.mm;
  e.is_signed = rule.sgn;
  if ((is_vec && (f3 == 3'b100)) || (e.cfgsel == VSETVLI) || (e.cfgsel == VSETVL)) begin
    e.rs1_kind = X;
  end else if ((is_vec && (f3 == 3'b011)) || (e.cfgsel == VSETIVLI)) begin
    e.rs1_kind = I;
  end else begin
    e.rs1_kind = V;
  end
  shift = legal_op && ((rule.alu == SLL) || (rule.alu == SRL) || (rule.alu == SRA));
  e.sign_extend   = !(shift || (e.cfgsel == VSETIVLI));
  e.single_bit_op = legal_op && (rule.alu == COMP);
  e.rev           = legal_op && (w[31:26] == 6'b000011);
  e.vm            = w[25];
  e.vwen          = legal_op;
  e.rd_scalar     = (e.cfgsel != NOT_CFG);
  e.vd            = w[11:7];
  e.vs1           = w[19:15];
  e.vs2           = w[24:20];
  return e;
endfunction

function automatic instr_t encode_vop(input logic [5:0] f6, input logic vm,
                                      input logic [4:0] vs2, input logic [4:0] vs1,
                                      input logic [2:0] f3, input logic [4:0] vd);
  return {f6, vm, vs2, vs1, f3, vd, 7'b1010111};
endfunction

// 60 kept ops, 15 config, 15 unknown or OPM and 10 non-vector
function automatic instr_t make_instr(input logic [31:0] r_sel, input logic [31:0] r_body);
  instr_t      w;
  logic [31:0] sel;
  w   = r_body;
  sel = r_sel % 32'd100;
  if (sel < 32'd60) begin
    w[6:0]   = 7'b1010111;
    w[31:26] = KEPT_FUNCT6[int'(r_sel[15:8] % 8'd21) * 6 +: 6];
    if (!r_sel[16]) begin
      case (r_sel[18:17])
        2'd0:    w[14:12] = 3'b000;
        2'd1:    w[14:12] = 3'b100;
        default: w[14:12] = 3'b011;
      endcase
    end
  end else if (sel < 32'd75) begin
    w[6:0]   = 7'b1010111;
    w[14:12] = 3'b111;
    case (r_sel[9:8])
      2'd0:    w[31] = 1'b0;
      2'd1:    w[31:30] = 2'b11;
      default: w[31:30] = 2'b10;
    endcase
  end else if (sel < 32'd90) begin
    w[6:0] = 7'b1010111;
    if (r_sel[8]) begin
      w[14:12] = r_sel[9] ? 3'b110 : 3'b010;
    end else begin
      // no supported code starts with 11
      w[31:30] = 2'b11;
      w[14:12] = r_sel[9] ? 3'b000 : 3'b100;
    end
  end else if (w[6:0] == 7'b1010111) begin
    w[0] = 1'b0;
  end
  return w;
endfunction

`endif

// ==== tb/vdec_tb.sv ====
`timescale 1ns/1ps

// vector decode pipeline testbench
// directed and random instructions against a reference model, with a
// credit returner, in-order scoreboard and a two-cycle latency check

`include "vdec_cfg.svh"

module vdec_tb import vinstr_pkg::*, vctrl_pkg::*;;

  localparam int N_DIRECTED = 7;
  localparam int N_RANDOM   = 400;

  logic   CLK = 1'b0;
  logic   arst_n;
  logic   instr_valid;
  instr_t instr;
  logic   instr_ready;
  logic   ctrl_valid;
  vctrl_s ctrl;
  logic   credit_return = 1'b0;

  int          errors = 0;
  int          cycle = 0;
  int          sent = 0;
  int          received = 0;
  int          held = 0;
  logic        hold_credits = 1'b0;
  logic [31:0] rng = 32'd48;
  // returner stream derived from the same seed
  logic [31:0] ret_rng = 32'd48 ^ 32'h5bd1_e995;
  vctrl_s      exp_q[$];
  int          acc_q[$];
  instr_t      directed[N_DIRECTED];

  `include "vdec_model.svh"

  vdec_top UUT (
    .CLK           (CLK),
    .arst_n        (arst_n),
    .instr_valid   (instr_valid),
    .instr         (instr),
    .instr_ready   (instr_ready),
    .ctrl_valid    (ctrl_valid),
    .ctrl          (ctrl),
    .credit_return (credit_return)
  );

  always #5 CLK = ~CLK;

  always @(posedge CLK) begin
    cycle <= cycle + 1;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] want);
    if (got !== want) begin
      errors++;
      $display("Mismatch %s: got 0x%0h expected 0x%0h at %0t", name, got, want, $time);
    end
  endtask

  task automatic note_failure(input string what);
    errors++;
    $display("Error: %s at %0t", what, $time);
  endtask

  task automatic compare_bundle(input vctrl_s got, input vctrl_s want);
    check("ctrl.illegal", 64'(got.illegal), 64'(want.illegal));
    check("ctrl.cfgsel", 64'(got.cfgsel), 64'(want.cfgsel));
    check("ctrl.aluop", 64'(got.aluop), 64'(want.aluop));
    check("ctrl.comp", 64'(got.comp), 64'(want.comp));
    check("ctrl.minmax", 64'(got.minmax), 64'(want.minmax));
    check("ctrl.is_signed", 64'(got.is_signed), 64'(want.is_signed));
    check("ctrl.rs1_kind", 64'(got.rs1_kind), 64'(want.rs1_kind));
    check("ctrl.sign_extend", 64'(got.sign_extend), 64'(want.sign_extend));
    check("ctrl.single_bit_op", 64'(got.single_bit_op), 64'(want.single_bit_op));
    check("ctrl.rev", 64'(got.rev), 64'(want.rev));
    check("ctrl.vm", 64'(got.vm), 64'(want.vm));
    check("ctrl.vwen", 64'(got.vwen), 64'(want.vwen));
    check("ctrl.rd_scalar", 64'(got.rd_scalar), 64'(want.rd_scalar));
    check("ctrl.vd", 64'(got.vd), 64'(want.vd));
    check("ctrl.vs1", 64'(got.vs1), 64'(want.vs1));
    check("ctrl.vs2", 64'(got.vs2), 64'(want.vs2));
  endtask

  // present one instruction and wait up to max_cycles for a free credit
  task automatic offer(input instr_t word, input int max_cycles, output logic taken);
    int waited;
    waited = 0;
    taken  = 1'b0;
    @(negedge CLK);
    instr_valid = 1'b1;
    instr       = word;
    while (!instr_ready && (waited < max_cycles)) begin
      @(negedge CLK);
      waited++;
    end
    if (instr_ready) begin
      taken = 1'b1;
      sent++;
      exp_q.push_back(expected_ctrl(word));
      // cycle in which the transfer takes place
      acc_q.push_back(cycle);
      @(posedge CLK);
    end else begin
      instr_valid = 1'b0;
    end
  endtask

  task automatic idle();
    @(negedge CLK);
    instr_valid = 1'b0;
  endtask

  // scoreboard and credit returner
  always @(negedge CLK) begin
    vctrl_s want;
    int     acc;
    if (!arst_n) begin
      credit_return = 1'b0;
    end else begin
      if (ctrl_valid) begin
        if (exp_q.size() == 0) begin
          note_failure("bundle emitted with no accepted instruction pending");
        end else begin
          want = exp_q.pop_front();
          acc  = acc_q.pop_front();
          compare_bundle(ctrl, want);
          check("ctrl_valid latency", 64'(cycle - acc), 64'd2);
        end
        received++;
        held++;
      end
      if (held > `VDEC_CREDITS) begin
        note_failure("more bundles outstanding than issue-queue slots");
      end
      credit_return = 1'b0;
      ret_rng = xorshift32(ret_rng);
      if (!hold_credits && (held > 0) && (ret_rng[1:0] != 2'b00)) begin
        credit_return = 1'b1;
        held--;
      end
    end
  end

  initial begin
    int          i;
    int          n_taken;
    int          waited;
    logic        taken;
    logic [31:0] r_sel;
    instr_t      word;
    arst_n      = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    // vsub.vi, vrsub.vv, vmsgt.vv, vsetvli, vsetivli, vsetvl, then an addi
    directed[0] = encode_vop(6'b000010, 1'b1, 5'd3, 5'd4, 3'b011, 5'd5);
    directed[1] = encode_vop(6'b000011, 1'b0, 5'd6, 5'd7, 3'b000, 5'd8);
    directed[2] = encode_vop(6'b011111, 1'b1, 5'd9, 5'd10, 3'b000, 5'd11);
    directed[3] = encode_vop(6'b000110, 1'b1, 5'd12, 5'd13, 3'b111, 5'd14);
    directed[4] = encode_vop(6'b110000, 1'b0, 5'd15, 5'd16, 3'b111, 5'd17);
    directed[5] = encode_vop(6'b100000, 1'b0, 5'd18, 5'd19, 3'b111, 5'd20);
    directed[6] = 32'h0050_0093;

    repeat (2) @(negedge CLK);
    arst_n = 1'b1;
    @(negedge CLK);
    check("instr_ready", 64'(instr_ready), 64'd1);
    check("ctrl_valid", 64'(ctrl_valid), 64'd0);

    // with no returns the pool runs dry after back-to-back accepts
    hold_credits = 1'b1;
    n_taken = 0;
    for (i = 0; i <= `VDEC_CREDITS; i++) begin
      offer(directed[i % N_DIRECTED], 2, taken);
      if (taken) begin
        n_taken++;
      end
    end
    check("accept count", 64'(n_taken), 64'(`VDEC_CREDITS));
    check("instr_ready", 64'(instr_ready), 64'd0);
    waited = 0;
    while ((received < `VDEC_CREDITS) && (waited < 20)) begin
      @(posedge CLK);
      waited++;
    end
    if (received < `VDEC_CREDITS) begin
      note_failure("timed out waiting for the bundles of the held credits");
    end
    @(negedge CLK);
    check("instr_ready", 64'(instr_ready), 64'd0);

    hold_credits = 1'b0;
    for (i = 0; i < N_DIRECTED; i++) begin
      offer(directed[i], 50, taken);
      if (!taken) begin
        note_failure("instruction not accepted after credits were returned");
      end
    end

    for (i = 0; i < N_RANDOM; i++) begin
      rng   = xorshift32(rng);
      r_sel = rng;
      rng   = xorshift32(rng);
      word  = make_instr(r_sel, rng);
      offer(word, 100, taken);
      if (!taken) begin
        note_failure("timed out waiting for instr_ready");
      end
      if (r_sel[21:20] == 2'b00) begin
        idle();
      end
    end
    idle();

    waited = 0;
    while ((exp_q.size() != 0) && (waited < 50)) begin
      @(posedge CLK);
      waited++;
    end
    if (exp_q.size() != 0) begin
      note_failure("timed out waiting for the pipeline to drain");
    end
    @(negedge CLK);
    check("bundle count", 64'(received), 64'(sent));

    $display("errors: %0d, bundles checked: %0d of %0d accepted", errors, received, sent);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== verilog/vctrl_gen.sv ====
`timescale 1ns/1ps

// vector decode stage 2
// turns the decoded operation into ALU selects, sign handling and
// write enables, and registers the bundle for the issue queue

module vctrl_gen import vctrl_pkg::*; (
  input  logic   CLK,
  input  logic   arst_n,
  input  logic   dec_valid,
  input  dec_s   dec,
  output logic   ctrl_valid,
  output vctrl_s ctrl
);

  aluop_t  aluop;
  comp_t   comp;
  minmax_t minmax;
  logic    is_signed;
  logic    is_shift;
  logic    is_compare;
  vctrl_s  ctrl_next;

  // BAD_OP falls to the defaults so illegal and config get ADD
  always_comb begin
    case (dec.op)
      OP_VADD:                         aluop = ADD;
      OP_VSUB, OP_VRSUB:               aluop = SUB;
      OP_VAND:                         aluop = AND;
      OP_VOR:                          aluop = OR;
      OP_VXOR:                         aluop = XOR;
      OP_VMSEQ, OP_VMSNE, OP_VMSLTU, OP_VMSLT,
      OP_VMSLEU, OP_VMSLE, OP_VMSGTU, OP_VMSGT: aluop = COMP;
      OP_VMINU, OP_VMIN, OP_VMAXU, OP_VMAX:     aluop = MM;
      OP_VSLL:                         aluop = SLL;
      OP_VSRL:                         aluop = SRL;
      OP_VSRA:                         aluop = SRA;
      default:                         aluop = ADD;
    endcase
  end

  always_comb begin
    case (dec.op)
      OP_VMSNE:  comp = VSNE;
      OP_VMSLTU: comp = VSLTU;
      OP_VMSLT:  comp = VSLT;
      OP_VMSLEU: comp = VSLEU;
      OP_VMSLE:  comp = VSLE;
      OP_VMSGTU: comp = VSGTU;
      OP_VMSGT:  comp = VSGT;
      default:   comp = VSEQ;
    endcase
  end

  always_comb begin
    case (dec.op)
      OP_VMINU: minmax = MINU;
      OP_VMAX:  minmax = MAX;
      OP_VMAXU: minmax = MAXU;
      default:  minmax = MIN;
    endcase
  end

  // one bit is enough without the multiply mixed-sign forms
  always_comb begin
    case (dec.op)
      OP_VADD, OP_VSUB, OP_VRSUB, OP_VMIN, OP_VMAX,
      OP_VMSEQ, OP_VMSNE, OP_VMSLT, OP_VMSLE, OP_VMSGT: is_signed = 1'b1;
      default: is_signed = 1'b0;
    endcase
  end

  assign is_shift   = (dec.op == OP_VSLL) || (dec.op == OP_VSRL) || (dec.op == OP_VSRA);
  assign is_compare = (aluop == COMP);

  always_comb begin
    ctrl_next               = '0;
    ctrl_next.illegal       = dec.illegal;
    ctrl_next.cfgsel        = dec.cfgsel;
    ctrl_next.aluop         = aluop;
    ctrl_next.comp          = comp;
    ctrl_next.minmax        = minmax;
    ctrl_next.is_signed     = is_signed;
    ctrl_next.rs1_kind      = dec.rs1_kind;
    // shift amounts and the vsetivli avl are zero extended
    ctrl_next.sign_extend   = !(is_shift || (dec.cfgsel == VSETIVLI));
    // compares write a mask bit per element
    ctrl_next.single_bit_op = is_compare;
    ctrl_next.rev           = (dec.op == OP_VRSUB);
    ctrl_next.vm            = dec.vm;
    ctrl_next.vwen          = !dec.illegal && (dec.cfgsel == NOT_CFG);
    ctrl_next.rd_scalar     = (dec.cfgsel != NOT_CFG);
    ctrl_next.vd            = dec.vd;
    ctrl_next.vs1           = dec.vs1;
    ctrl_next.vs2           = dec.vs2;
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      ctrl_valid <= 1'b0;
    end else begin
      ctrl_valid <= dec_valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (dec_valid) begin
      ctrl <= ctrl_next;
    end
  end

endmodule

// ==== verilog/vctrl_pkg.sv ====
// vector decode result types
// decoded operation, config form, operand kind, ALU selects and
// the packed bundles passed between and out of the decode stages

package vctrl_pkg;

  import vinstr_pkg::*;

  typedef enum logic [4:0] {
    OP_VADD, OP_VSUB, OP_VRSUB, OP_VMINU, OP_VMIN, OP_VMAXU, OP_VMAX,
    OP_VAND, OP_VOR, OP_VXOR,
    OP_VMSEQ, OP_VMSNE, OP_VMSLTU, OP_VMSLT, OP_VMSLEU, OP_VMSLE,
    OP_VMSGTU, OP_VMSGT,
    OP_VSLL, OP_VSRL, OP_VSRA,
    BAD_OP = 5'h1f
  } vop_t;

  typedef enum logic [1:0] {NOT_CFG, VSETVLI, VSETIVLI, VSETVL} cfgsel_t;

  // source of the rs1 operand
  typedef enum logic [1:0] {V, X, I} rs1_kind_t;

  // ALU function of the execution unit
  typedef enum logic [3:0] {
    ADD, SUB, AND, OR, XOR, COMP, MM, SLL, SRL, SRA
  } aluop_t;

  typedef enum logic [2:0] {
    VSEQ, VSNE, VSLTU, VSLT, VSLEU, VSLE, VSGTU, VSGT
  } comp_t;

  typedef enum logic [1:0] {MIN, MINU, MAX, MAXU} minmax_t;

  // stage 1 result
  typedef struct packed {
    vop_t      op;
    cfgsel_t   cfgsel;
    logic      illegal;
    rs1_kind_t rs1_kind;
    logic      vm;
    reg_idx_t  vd;
    reg_idx_t  vs1;
    reg_idx_t  vs2;
  } dec_s;

  // bundle sent to the issue queue
  typedef struct packed {
    logic      illegal;
    cfgsel_t   cfgsel;
    aluop_t    aluop;
    comp_t     comp;
    minmax_t   minmax;
    logic      is_signed;
    rs1_kind_t rs1_kind;
    logic      sign_extend;
    logic      single_bit_op;
    logic      rev;
    logic      vm;
    logic      vwen;
    logic      rd_scalar;
    reg_idx_t  vd;
    reg_idx_t  vs1;
    reg_idx_t  vs2;
  } vctrl_s;

endpackage

// ==== verilog/vdec_cfg.svh ====
// vector decode configuration
// widths and the issue-queue credit depth shared by the decode pipeline

`ifndef VDEC_CFG_SVH
`define VDEC_CFG_SVH

// instruction word width
`define VDEC_XLEN 32

// register index and imm5 width
`define VDEC_REG_W 5

// issue-queue slots available to the decoder
`define VDEC_CREDITS 4

// credit counter width that must hold VDEC_CREDITS
`define VDEC_CREDIT_W 3

`endif

// ==== verilog/vdec_credit.sv ====
`timescale 1ns/1ps

// decode credit counter
// tracks free issue-queue slots, raises ready while one is free and
// produces the accept strobe for the instruction port

`include "vdec_cfg.svh"

module vdec_credit (
  input  logic CLK,
  input  logic arst_n,
  input  logic instr_valid,
  input  logic credit_return,
  output logic instr_ready,
  output logic accept
);

  localparam logic [`VDEC_CREDIT_W-1:0] MAX_CREDITS = `VDEC_CREDITS;

  logic [`VDEC_CREDIT_W-1:0] credits;

  assign instr_ready = (credits != '0);
  assign accept      = instr_valid && instr_ready;

  // accept and return in one cycle cancel out
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      credits <= MAX_CREDITS;
    end else if (accept && !credit_return) begin
      credits <= credits - 1'b1;
    end else if (!accept && credit_return && (credits != MAX_CREDITS)) begin
      // saturate at the pool size
      credits <= credits + 1'b1;
    end
  end

endmodule

// ==== verilog/vdec_top.sv ====
`timescale 1ns/1ps

// vector decode pipeline top
// credit-gated instruction port, two registered decode stages and
// the control bundle output toward the issue queue

module vdec_top import vinstr_pkg::*, vctrl_pkg::*; (
  input  logic   CLK,
  input  logic   arst_n,
  input  logic   instr_valid,
  input  instr_t instr,
  output logic   instr_ready,
  output logic   ctrl_valid,
  output vctrl_s ctrl,
  input  logic   credit_return
);

  logic accept;
  logic dec_valid;
  dec_s dec;

  vdec_credit u_credit (
    .CLK           (CLK),
    .arst_n        (arst_n),
    .instr_valid   (instr_valid),
    .credit_return (credit_return),
    .instr_ready   (instr_ready),
    .accept        (accept)
  );

  vop_decoder u_decoder (
    .CLK       (CLK),
    .arst_n    (arst_n),
    .accept    (accept),
    .instr     (instr),
    .dec_valid (dec_valid),
    .dec       (dec)
  );

  vctrl_gen u_ctrl_gen (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .dec_valid  (dec_valid),
    .dec        (dec),
    .ctrl_valid (ctrl_valid),
    .ctrl       (ctrl)
  );

endmodule

// ==== verilog/vinstr_pkg.sv ====
// vector instruction encoding types
// raw instruction word, register index, opcode and function
// fields of the OPI / config subset of the vector extension

package vinstr_pkg;

`include "vdec_cfg.svh"

  typedef logic [`VDEC_XLEN-1:0]  instr_t;
  typedef logic [`VDEC_REG_W-1:0] reg_idx_t;

  // only the vector major opcodes get names
  typedef enum logic [6:0] {
    VECTOR  = 7'b1010111,
    LOAD_FP = 7'b0000111
  } opcode_t;

  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPFVV = 3'b001,
    OPMVV = 3'b010,
    OPIVI = 3'b011,
    OPIVX = 3'b100,
    OPFVF = 3'b101,
    OPMVX = 3'b110,
    OPCFG = 3'b111
  } vfunct3_t;

  // funct6 codes of the supported OPI operations
  typedef enum logic [5:0] {
    VADD   = 6'b000000,
    VSUB   = 6'b000010,
    VRSUB  = 6'b000011,
    VMINU  = 6'b000100,
    VMIN   = 6'b000101,
    VMAXU  = 6'b000110,
    VMAX   = 6'b000111,
    VAND   = 6'b001001,
    VOR    = 6'b001010,
    VXOR   = 6'b001011,
    VMSEQ  = 6'b011000,
    VMSNE  = 6'b011001,
    VMSLTU = 6'b011010,
    VMSLT  = 6'b011011,
    VMSLEU = 6'b011100,
    VMSLE  = 6'b011101,
    VMSGTU = 6'b011110,
    VMSGT  = 6'b011111,
    VSLL   = 6'b100101,
    VSRL   = 6'b101000,
    VSRA   = 6'b101001
  } vopi_t;

  // arithmetic format with the msb first
  typedef struct packed {
    vopi_t    funct6;
    logic     vm;
    reg_idx_t vs2;
    reg_idx_t vs1;
    vfunct3_t funct3;
    reg_idx_t vd;
    opcode_t  opcode;
  } vinstr_s;

endpackage

// ==== verilog/vop_decoder.sv ====
`timescale 1ns/1ps

// vector decode stage 1
// splits the instruction, finds the config form and the OPI operation,
// applies the funct3 legality rule and registers the result on accept

module vop_decoder import vinstr_pkg::*, vctrl_pkg::*; (
  input  logic   CLK,
  input  logic   arst_n,
  input  logic   accept,
  input  instr_t instr,
  output logic   dec_valid,
  output dec_s   dec
);

  vinstr_s   fields;
  logic      is_vector;
  logic      ok_vvxi;
  logic      ok_vvx;
  logic      ok_xi;
  vop_t      op;
  cfgsel_t   cfgsel;
  rs1_kind_t rs1_kind;
  logic      illegal;
  dec_s      dec_next;

  assign fields    = vinstr_s'(instr);
  assign is_vector = (fields.opcode == VECTOR);

  // funct3 groups an OPI operation may be legal with
  assign ok_vvxi = is_vector && ((fields.funct3 == OPIVV) || (fields.funct3 == OPIVX) ||
                                 (fields.funct3 == OPIVI));
  assign ok_vvx  = is_vector && ((fields.funct3 == OPIVV) || (fields.funct3 == OPIVX));
  assign ok_xi   = is_vector && ((fields.funct3 == OPIVX) || (fields.funct3 == OPIVI));

  // config form from the top two bits
  always_comb begin
    cfgsel = NOT_CFG;
    if (is_vector && (fields.funct3 == OPCFG)) begin
      if (!instr[31]) begin
        cfgsel = VSETVLI;
      end else if (instr[30]) begin
        cfgsel = VSETIVLI;
      end else begin
        cfgsel = VSETVL;
      end
    end
  end

  // OPM / OPF never match since the ok flags need an OPI funct3
  always_comb begin
    op = BAD_OP;
    case (fields.funct6)
      VADD:   if (ok_vvxi) op = OP_VADD;
      VSUB:   if (ok_vvx)  op = OP_VSUB;
      VRSUB:  if (ok_xi)   op = OP_VRSUB;
      VMINU:  if (ok_vvx)  op = OP_VMINU;
      VMIN:   if (ok_vvx)  op = OP_VMIN;
      VMAXU:  if (ok_vvx)  op = OP_VMAXU;
      VMAX:   if (ok_vvx)  op = OP_VMAX;
      VAND:   if (ok_vvxi) op = OP_VAND;
      VOR:    if (ok_vvxi) op = OP_VOR;
      VXOR:   if (ok_vvxi) op = OP_VXOR;
      VMSEQ:  if (ok_vvxi) op = OP_VMSEQ;
      VMSNE:  if (ok_vvxi) op = OP_VMSNE;
      VMSLTU: if (ok_vvx)  op = OP_VMSLTU;
      VMSLT:  if (ok_vvx)  op = OP_VMSLT;
      VMSLEU: if (ok_vvxi) op = OP_VMSLEU;
      VMSLE:  if (ok_vvxi) op = OP_VMSLE;
      VMSGTU: if (ok_xi)   op = OP_VMSGTU;
      VMSGT:  if (ok_xi)   op = OP_VMSGT;
      VSLL:   if (ok_vvxi) op = OP_VSLL;
      VSRL:   if (ok_vvxi) op = OP_VSRL;
      VSRA:   if (ok_vvxi) op = OP_VSRA;
      default: op = BAD_OP;
    endcase
  end

  // config instructions are always legal
  assign illegal = !is_vector || ((cfgsel == NOT_CFG) && (op == BAD_OP));

  always_comb begin
    rs1_kind = V;
    if ((is_vector && (fields.funct3 == OPIVX)) || (cfgsel == VSETVLI) ||
        (cfgsel == VSETVL)) begin
      rs1_kind = X;
    end else if ((is_vector && (fields.funct3 == OPIVI)) || (cfgsel == VSETIVLI)) begin
      rs1_kind = I;
    end
  end

  always_comb begin
    dec_next          = '0;
    dec_next.op       = op;
    dec_next.cfgsel   = cfgsel;
    dec_next.illegal  = illegal;
    dec_next.rs1_kind = rs1_kind;
    dec_next.vm       = fields.vm;
    dec_next.vd       = fields.vd;
    dec_next.vs1      = fields.vs1;
    dec_next.vs2      = fields.vs2;
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= accept;
    end
  end

  // payload only moves on an accepted instruction
  always_ff @(posedge CLK) begin
    if (accept) begin
      dec <= dec_next;
    end
  end

endmodule
